// File: bench/tb_rv_retire.sv
`timescale 1ns/10ps

`include "rv_params.svh"

module tb_rv_retire
    import rv_isa_pkg::*;
();

    localparam int CYCLE_LIMIT = 3000;   // 300 retires of a few cycles each.
    localparam int NUM_ALU     = 120;
    localparam int NUM_LOAD    = 100;
    localparam int NUM_MISC    = 79;
    localparam int NUM_HALTED  = 10;

    logic              clk;
    logic              reset;
    logic              retire;
    logic [`XLEN-1:0]  pc;
    wb_sel_t           wb_sel;
    logic [4:0]        wb_addr;
    logic              rf_wen;
    logic              br_flg;
    logic [`XLEN-1:0]  br_target;
    logic              jmp_flg;
    logic [`XLEN-1:0]  alu_out;
    logic              is_ecall;
    logic [`XLEN-1:0]  trap_vector;
    csr_sel_t          csr_sel;
    logic [`XLEN-1:0]  mem_rdata;
    logic              mem_valid;
    logic [4:0]        rs_addr;
    logic [`XLEN-1:0]  rs_data;
    logic [`XLEN-1:0]  next_pc;
    logic              redirect;
    logic              pc_valid;
    logic              busy;
    logic              halted;

    // reference model.
    logic [`XLEN-1:0]  model_regs [`REG_COUNT];
    logic [`XLEN-1:0]  model_cycle;
    logic [`XLEN-1:0]  model_instret;
    logic [31:0]       rng_state = 32'h2f4d_1dbb;
    int                cycle_count = 0;

    rv_retire_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers.
    ////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            fail_run($sformatf("%s mismatch", name));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_value(name, {31'b0, expected}, {31'b0, actual});
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // word aligned and never the exit address.
    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = next_rand() & 32'hffff_fffc;
        if (r == `EXIT_PC) begin
            r = r + 32'd8;
        end
        return r;
    endfunction

    function automatic logic [31:0] load_value(input wb_sel_t sel, input logic [31:0] data);
        case (sel)
            WB_MEMB:  return {{24{data[7]}}, data[7:0]};
            WB_MEMBU: return {24'b0, data[7:0]};
            WB_MEMH:  return {{16{data[15]}}, data[15:0]};
            WB_MEMHU: return {16'b0, data[15:0]};
            default:  return data;
        endcase
    endfunction

    // flags are {br, jmp, ecall}.
    function automatic logic [31:0] expected_next_pc(input logic [2:0] flags,
        input logic [31:0] pc_val, input logic [31:0] tgt, input logic [31:0] alu,
        input logic [31:0] trap);
        if (flags[2]) begin
            return tgt;
        end else if (flags[1]) begin
            return alu;
        end else if (flags[0]) begin
            return trap;
        end
        return pc_val + 32'd4;
    endfunction

    task automatic wait_commit(output int waited);
        waited = 0;
        @(negedge clk);
        while (!pc_valid) begin
            if (waited >= 8) begin
                fail_run("pc_valid never came after the retire");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic sweep_registers();
        for (int i = 0; i < `REG_COUNT; i++) begin
            @(posedge clk);
            rs_addr <= 5'(i);
            @(negedge clk);
            check_value($sformatf("x%0d sweep", i), model_regs[i], rs_data);
        end
    endtask

    ////////////////////////////////////////
    // one instruction, retire to readback.
    ////////////////////////////////////////

    task automatic retire_one(input wb_sel_t sel, input logic [4:0] addr, input logic wen,
        input logic [31:0] pc_val, input logic [2:0] flags, input csr_sel_t csr);
        logic [31:0] tgt;
        logic [31:0] alu;
        logic [31:0] trap;
        logic [31:0] mdata;
        logic [31:0] stray;
        logic [31:0] exp_wb;
        int          lat;
        int          waited;
        logic        is_load;
        tgt   = next_rand();
        alu   = next_rand();
        trap  = next_rand();
        mdata = next_rand();
        stray = next_rand();
        lat   = int'(stray[2:0]);   // 0 to 7 cycles.
        is_load = sel inside {WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW};

        @(posedge clk);
        retire      <= 1'b1;
        pc          <= pc_val;
        wb_sel      <= sel;
        wb_addr     <= addr;
        rf_wen      <= wen;
        br_flg      <= flags[2];
        jmp_flg     <= flags[1];
        is_ecall    <= flags[0];
        br_target   <= tgt;
        alu_out     <= alu;
        trap_vector <= trap;
        csr_sel     <= csr;
        @(negedge clk);
        check_bit("pc_valid at retire", 1'b0, pc_valid);
        @(posedge clk);
        retire <= 1'b0;
        if (is_load) begin
            repeat (lat) begin
                @(negedge clk);
                check_bit("busy during load wait", 1'b1, busy);
                check_bit("pc_valid during load wait", 1'b0, pc_valid);
                @(posedge clk);
                stray = next_rand();
                retire    <= stray[0];   // must be dropped.
                pc        <= `EXIT_PC;
                wb_sel    <= WB_ALU;
                wb_addr   <= stray[5:1];
                mem_rdata <= ~mdata;
            end
            mem_rdata <= mdata;
            mem_valid <= 1'b1;
            @(negedge clk);
            check_bit("busy with mem_valid", 1'b1, busy);
            @(posedge clk);
            mem_valid <= 1'b0;
            retire    <= stray[0];   // lands in the commit cycle.
        end
        wait_commit(waited);
        check_value("commit delay", 32'd0, 32'(waited));
        check_bit("busy at commit", 1'b1, busy);
        check_value("next_pc", expected_next_pc(flags, pc_val, tgt, alu, trap), next_pc);
        check_bit("redirect", |flags, redirect);

        if (is_load) begin
            exp_wb = load_value(sel, mdata);
        end else if (sel == WB_PC) begin
            exp_wb = pc_val + 32'd4;
        end else if (sel == WB_CSR) begin
            exp_wb = (csr == CSR_INSTRET) ? model_instret : model_cycle;
        end else begin
            exp_wb = alu;
        end
        if (wen && (addr != 5'd0)) begin
            model_regs[addr] = exp_wb;
        end
        model_instret = model_instret + 32'd1;

        @(posedge clk);
        retire  <= 1'b0;
        rs_addr <= addr;
        @(negedge clk);
        check_bit("pc_valid after commit", 1'b0, pc_valid);
        check_bit("halted", pc_val == `EXIT_PC, halted);
        check_value($sformatf("x%0d after writeback", addr), model_regs[addr], rs_data);
    endtask

    task automatic strobes_after_halt(input int count);
        logic [31:0] r;
        repeat (count) begin
            @(posedge clk);
            r = next_rand();
            retire    <= 1'b1;
            pc        <= random_pc();
            wb_sel    <= wb_sel_t'({1'b0, r[2:0]});
            wb_addr   <= r[8:4];
            rf_wen    <= 1'b1;
            alu_out   <= next_rand();
            mem_valid <= r[9];
            @(posedge clk);
            retire    <= 1'b0;
            mem_valid <= 1'b0;
            @(negedge clk);
            check_bit("pc_valid while halted", 1'b0, pc_valid);
            check_bit("halted stays set", 1'b1, halted);
            check_bit("busy while halted", 1'b0, busy);
        end
    endtask

    ////////////////////////////////////////
    // model counter, timeout, properties.
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            model_cycle <= '0;
        end else begin
            model_cycle <= model_cycle + 32'd1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    assert property (@(posedge clk) disable iff (reset) pc_valid |-> busy)
        else fail_run("pc_valid seen outside a busy cycle");
    assert property (@(posedge clk) disable iff (reset) $past(halted) |-> halted)
        else fail_run("halted dropped without a reset");
    assert property (@(posedge clk) disable iff (reset) !(halted && busy))
        else fail_run("busy and halted at the same time");
    assert property (@(posedge clk) disable iff (reset) (rs_addr == 5'd0) |-> (rs_data == '0))
        else begin
            $display("ERR x0 read: expected %h, actual %h", 32'h0, $sampled(rs_data));
            fail_run("x0 read back nonzero");
        end

    ////////////////////////////////////////
    // test sequence.
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        reset       <= 1'b1;
        retire      <= 1'b0;
        pc          <= '0;
        wb_sel      <= WB_ALU;
        wb_addr     <= '0;
        rf_wen      <= 1'b0;
        br_flg      <= 1'b0;
        br_target   <= '0;
        jmp_flg     <= 1'b0;
        alu_out     <= '0;
        is_ecall    <= 1'b0;
        trap_vector <= '0;
        csr_sel     <= CSR_CYCLE;
        mem_rdata   <= '0;
        mem_valid   <= 1'b0;
        rs_addr     <= '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        model_instret = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // state right after reset.
        @(negedge clk);
        check_bit("busy after reset", 1'b0, busy);
        check_bit("halted after reset", 1'b0, halted);
        check_bit("pc_valid after reset", 1'b0, pc_valid);
        check_value("next_pc after reset", `RESET_PC, next_pc);
        sweep_registers();

        for (int i = 0; i < NUM_ALU; i++) begin
            retire_one(WB_ALU, 5'(next_rand()), 1'b1, random_pc(), 3'(i), CSR_CYCLE);
        end

        // all five load widths.
        for (int i = 0; i < NUM_LOAD; i++) begin
            r = next_rand();
            retire_one(wb_sel_t'(4'(1 + i % 5)), r[4:0], 1'b1, random_pc(), r[7:5],
                       csr_sel_t'(r[8]));
        end

        for (int i = 0; i < NUM_MISC; i++) begin
            r = next_rand();
            retire_one((i % 3 == 0) ? WB_PC : (i % 3 == 1) ? WB_CSR : WB_ALU,
                       (i % 4 == 0) ? 5'd0 : r[4:0], (i % 4 != 1), random_pc(), r[7:5],
                       csr_sel_t'(r[8]));
        end

        retire_one(WB_ALU, 5'd5, 1'b1, `EXIT_PC, 3'b000, CSR_CYCLE);
        strobes_after_halt(NUM_HALTED);
        sweep_registers();

        $display("All checks passed");
        $finish;
    end

endmodule

// File: hw/perf_counters.sv
`timescale 1ns/10ps

`include "rv_params.svh"

module perf_counters
    import rv_isa_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  csr_sel_t          csr_sel,
    output logic [`XLEN-1:0]  csr_rdata
);

    logic [`XLEN-1:0] cycle_cnt;
    logic [`XLEN-1:0] instret_cnt;

    ////////////////////////////////////////
    // counters.
    ////////////////////////////////////////

    // free running, wraps.
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // one per committed instruction.
    always_ff @(posedge clk) begin
        if (reset) begin
            instret_cnt <= '0;
        end else if (commit) begin
            instret_cnt <= instret_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // csr read mux.
    ////////////////////////////////////////

    // value before this commit's own increment.
    always_comb begin
        case (csr_sel)
            CSR_CYCLE: begin
                csr_rdata = cycle_cnt;
            end
            CSR_INSTRET: begin
                csr_rdata = instret_cnt;
            end
            default: begin
                csr_rdata = cycle_cnt;
            end
        endcase
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/10ps

`include "rv_params.svh"

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  logic              rf_wen_q,
    input  logic [4:0]        wb_addr_q,
    input  logic [4:0]        rs_addr,
    input  logic [`XLEN-1:0]  wb_data,
    output logic [`XLEN-1:0]  rs_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wr_en;

    // x0 is never written, so it stays zero after reset.
    assign wr_en = commit && rf_wen_q && (wb_addr_q != 5'd0);

    ////////////////////////////////////////
    // write port.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_addr_q] <= wb_data;
        end
    end

    ////////////////////////////////////////
    // read port.
    ////////////////////////////////////////

    assign rs_data = regs[rs_addr];   // async read.

endmodule

// File: hw/retire_fsm.sv
`timescale 1ns/10ps

`include "rv_params.svh"

module retire_fsm
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              retire,
    input  logic              mem_valid,
    input  wb_sel_t           wb_sel,
    input  logic [`XLEN-1:0]  pc_q,
    output logic              capture,
    output logic              mem_capture,
    output logic              commit,
    output logic              busy,
    output logic              halted
);

    retire_state_t state;
    retire_state_t state_next;
    logic          is_load;

    // the five memory selects need read data first.
    always_comb begin
        case (wb_sel)
            WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW: begin
                is_load = 1'b1;
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // strobes and levels.
    ////////////////////////////////////////

    assign capture     = retire && (state == ST_IDLE);   // ignored when busy or halted.
    assign mem_capture = mem_valid && (state == ST_WAIT_MEM);
    assign commit      = (state == ST_COMMIT);
    assign busy        = (state == ST_WAIT_MEM) || (state == ST_COMMIT);
    assign halted      = (state == ST_HALT);

    ////////////////////////////////////////
    // next state.
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (retire) begin
                    state_next = is_load ? ST_WAIT_MEM : ST_COMMIT;
                end
            end
            ST_WAIT_MEM: begin
                if (mem_valid) begin
                    state_next = ST_COMMIT;
                end
            end
            ST_COMMIT: begin
                // exit pc stops everything after its own commit.
                if (pc_q == `EXIT_PC) begin
                    state_next = ST_HALT;
                end else begin
                    state_next = ST_IDLE;
                end
            end
            ST_HALT: begin
                state_next = ST_HALT;   // only reset leaves.
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: hw/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // retire sequencer states.
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,   // waiting for a retire strobe.
        ST_WAIT_MEM = 2'd1,   // load issued, data not back yet.
        ST_COMMIT   = 2'd2,   // one cycle, regfile write and pc out.
        ST_HALT     = 2'd3    // exit pc retired, sticky.
    } retire_state_t;

endpackage

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    ////////////////////////////////////////
    // writeback source select.
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        WB_ALU   = 4'd0,   // alu result.
        WB_MEMB  = 4'd1,   // signed byte load.
        WB_MEMBU = 4'd2,   // unsigned byte load.
        WB_MEMH  = 4'd3,   // signed half load.
        WB_MEMHU = 4'd4,   // unsigned half load.
        WB_MEMW  = 4'd5,   // word load.
        WB_PC    = 4'd6,   // link address, pc+4.
        WB_CSR   = 4'd7    // counter read.
    } wb_sel_t;

    ////////////////////////////////////////
    // csr read select.
    ////////////////////////////////////////

    typedef enum logic {
        CSR_CYCLE   = 1'b0,
        CSR_INSTRET = 1'b1
    } csr_sel_t;

endpackage

// File: hw/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width.
`define XLEN 32

// architectural registers, x0 included.
`define REG_COUNT 32

// retiring this pc stops the unit.
`define EXIT_PC 32'h0000_0044
`define RESET_PC 32'h0000_0000

`endif

// File: hw/rv_retire_top.sv
`timescale 1ns/10ps

`include "rv_params.svh"

module rv_retire_top
    import rv_isa_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // retiring instruction.
    input  logic              retire,
    input  logic [`XLEN-1:0]  pc,
    input  wb_sel_t           wb_sel,
    input  logic [4:0]        wb_addr,
    input  logic              rf_wen,
    input  logic              br_flg,
    input  logic [`XLEN-1:0]  br_target,
    input  logic              jmp_flg,
    input  logic [`XLEN-1:0]  alu_out,
    input  logic              is_ecall,
    input  logic [`XLEN-1:0]  trap_vector,
    input  csr_sel_t          csr_sel,

    // load return.
    input  logic [`XLEN-1:0]  mem_rdata,
    input  logic              mem_valid,

    // register read port.
    input  logic [4:0]        rs_addr,
    output logic [`XLEN-1:0]  rs_data,

    // pc out and status.
    output logic [`XLEN-1:0]  next_pc,
    output logic              redirect,
    output logic              pc_valid,
    output logic              busy,
    output logic              halted
);

    logic             capture;
    logic             mem_capture;
    logic             commit;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] wb_data;
    logic [`XLEN-1:0] csr_rdata;
    logic [4:0]       wb_addr_q;
    logic             rf_wen_q;
    csr_sel_t         csr_sel_q;

    assign pc_valid = commit;   // next_pc is good in the commit cycle.

    ////////////////////////////////////////
    // control.
    ////////////////////////////////////////

    retire_fsm i_retire_fsm (
        .clk         (clk),
        .reset       (reset),
        .retire      (retire),
        .mem_valid   (mem_valid),
        .wb_sel      (wb_sel),
        .pc_q        (pc_q),
        .capture     (capture),
        .mem_capture (mem_capture),
        .commit      (commit),
        .busy        (busy),
        .halted      (halted)
    );

    perf_counters i_perf_counters (
        .clk       (clk),
        .reset     (reset),
        .commit    (commit),
        .csr_sel   (csr_sel_q),
        .csr_rdata (csr_rdata)
    );

    ////////////////////////////////////////
    // datapath.
    ////////////////////////////////////////

    wb_stage i_wb_stage (
        .clk         (clk),
        .reset       (reset),
        .capture     (capture),
        .mem_capture (mem_capture),
        .pc          (pc),
        .alu_out     (alu_out),
        .br_target   (br_target),
        .trap_vector (trap_vector),
        .mem_rdata   (mem_rdata),
        .csr_rdata   (csr_rdata),
        .wb_sel      (wb_sel),
        .csr_sel     (csr_sel),
        .wb_addr     (wb_addr),
        .rf_wen      (rf_wen),
        .br_flg      (br_flg),
        .jmp_flg     (jmp_flg),
        .is_ecall    (is_ecall),
        .wb_data     (wb_data),
        .next_pc     (next_pc),
        .pc_q        (pc_q),
        .wb_addr_q   (wb_addr_q),
        .rf_wen_q    (rf_wen_q),
        .redirect    (redirect),
        .csr_sel_q   (csr_sel_q)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .reset     (reset),
        .commit    (commit),
        .rf_wen_q  (rf_wen_q),
        .wb_addr_q (wb_addr_q),
        .rs_addr   (rs_addr),
        .wb_data   (wb_data),
        .rs_data   (rs_data)
    );

endmodule

// File: hw/wb_stage.sv
`timescale 1ns/10ps

`include "rv_params.svh"

module wb_stage
    import rv_isa_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              capture,
    input  logic              mem_capture,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  alu_out,
    input  logic [`XLEN-1:0]  br_target,
    input  logic [`XLEN-1:0]  trap_vector,
    input  logic [`XLEN-1:0]  mem_rdata,
    input  logic [`XLEN-1:0]  csr_rdata,
    input  wb_sel_t           wb_sel,
    input  csr_sel_t          csr_sel,
    input  logic [4:0]        wb_addr,
    input  logic              rf_wen,
    input  logic              br_flg,
    input  logic              jmp_flg,
    input  logic              is_ecall,
    output logic [`XLEN-1:0]  wb_data,
    output logic [`XLEN-1:0]  next_pc,
    output logic [`XLEN-1:0]  pc_q,
    output logic [4:0]        wb_addr_q,
    output logic              rf_wen_q,
    output logic              redirect,
    output csr_sel_t          csr_sel_q
);

    wb_sel_t          wb_sel_q;
    logic [`XLEN-1:0] alu_q;
    logic [`XLEN-1:0] mem_q;
    logic [`XLEN-1:0] pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            rf_wen_q  <= 1'b0;
            wb_sel_q  <= WB_ALU;
            csr_sel_q <= CSR_CYCLE;
            next_pc   <= `RESET_PC;
            redirect  <= 1'b0;
        end else if (capture) begin
            rf_wen_q  <= rf_wen;
            wb_sel_q  <= wb_sel;
            csr_sel_q <= csr_sel;
            // branch wins over jump, jump over ecall.
            next_pc   <= br_flg   ? br_target :
                         jmp_flg  ? alu_out :
                         is_ecall ? trap_vector : pc_plus4;
            redirect  <= br_flg || jmp_flg || is_ecall;
        end
    end

    // payload, only read while committing.
    always_ff @(posedge clk) begin
        if (capture) begin
            pc_q      <= pc;
            alu_q     <= alu_out;
            wb_addr_q <= wb_addr;
        end
        if (mem_capture) begin
            mem_q <= mem_rdata;
        end
    end

    always_comb begin
        case (wb_sel_q)
            WB_MEMB:  wb_data = {{24{mem_q[7]}}, mem_q[7:0]};
            WB_MEMBU: wb_data = {24'b0, mem_q[7:0]};
            WB_MEMH:  wb_data = {{16{mem_q[15]}}, mem_q[15:0]};
            WB_MEMHU: wb_data = {16'b0, mem_q[15:0]};
            WB_MEMW:  wb_data = mem_q;
            WB_PC:    wb_data = pc_q + 32'd4;   // link.
            WB_CSR:   wb_data = csr_rdata;
            default:  wb_data = alu_q;
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_rv_retire -o tb_rv_retire \
    && ./obj_dir/tb_rv_retire \
    || exit 1

// File: sim.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/retire_fsm.sv
hw/perf_counters.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/rv_retire_top.sv
bench/tb_rv_retire.sv
